//--- all.f
+incdir+.
common_pkg.sv
control.sv
registers.sv
imm_gen.sv
instruction_decode_stage.sv
id_ex_reg.sv
decode_top.sv
decode_asserts.sv
tb_decode.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) rv_cfg.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_decode.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_decode;

  localparam int TIMEOUT = 20; // cycles allowed for out_valid.

  logic                     clk;
  logic                     rst;
  common_pkg::instruction_t instruction;
  logic [`RV_XLEN-1:0]      pc;
  logic                     in_valid;
  logic                     reg_write;
  logic [`RV_REG_ID_W-1:0]  write_id;
  logic [`RV_XLEN-1:0]      write_data;
  logic                     out_valid;
  common_pkg::id_ex_t       id_ex;

  logic [31:0]          lcg_state = 32'he5ad;
  logic [31:0]          tab_word [$];
  logic [31:0]          tab_imm [$];
  common_pkg::control_t tab_ctl [$];
  logic [`RV_XLEN-1:0]  reg_model [`RV_NUM_REGS];

  decode_top i_decode_top (
    .clk         (clk),
    .rst         (rst),
    .instruction (instruction),
    .pc          (pc),
    .in_valid    (in_valid),
    .reg_write   (reg_write),
    .write_id    (write_id),
    .write_data  (write_data),
    .out_valid   (out_valid),
    .id_ex       (id_ex)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // add x0, rs1, rs2.
  function automatic logic [31:0] r_type(input logic [4:0] rs1, input logic [4:0] rs2);
    return {7'd0, rs2, rs1, 3'd0, 5'd0, common_pkg::OP};
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: %s expected %h actual %h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic wait_out();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!out_valid) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("out_valid did not rise within %0d cycles", TIMEOUT);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
      end
      @(negedge clk);
    end
  endtask

  // one valid instruction, with an optional write-back in the same cycle.
  task automatic issue(input logic [31:0] word, input logic [31:0] pc_val, input logic we,
                       input logic [4:0] wid, input logic [31:0] wdata);
    @(posedge clk);
    instruction <= word;
    pc          <= pc_val;
    in_valid    <= 1'b1;
    reg_write   <= we;
    write_id    <= wid;
    write_data  <= wdata;
    @(posedge clk);
    in_valid    <= 1'b0;
    reg_write   <= 1'b0;
    wait_out();
  endtask

  task automatic write_reg(input logic [4:0] id, input logic [31:0] data);
    @(posedge clk);
    in_valid   <= 1'b0;
    reg_write  <= 1'b1;
    write_id   <= id;
    write_data <= data;
  endtask

  // flags are {alu_src, mem_read, mem_write, mem_to_reg, is_branch, reg_write}.
  task automatic entry(input logic [31:0] word, input logic [31:0] imm,
                       input common_pkg::encoding_t enc, input common_pkg::alu_op_t op,
                       input logic [5:0] flags, input logic [4:0] id);
    common_pkg::control_t c;
    c = {enc, op, flags, id};
    tab_word.push_back(word);
    tab_imm.push_back(imm);
    tab_ctl.push_back(c);
  endtask

  task automatic fill_table();
    entry(32'h002081B3, 32'h0, common_pkg::R_TYPE, common_pkg::ALU_ADD, 6'b000001, 5'd3);
    entry(32'h40208233, 32'h0, common_pkg::R_TYPE, common_pkg::ALU_SUB, 6'b000001, 5'd4);
    entry(32'h4020D2B3, 32'h0, common_pkg::R_TYPE, common_pkg::ALU_SHIFT_RIGHT_AR,
          6'b000001, 5'd5);
    entry(32'h0020B333, 32'h0, common_pkg::R_TYPE, common_pkg::ALU_LESS_THAN_UNSIGNED,
          6'b000001, 5'd6);
    entry(32'hFFF08393, 32'hFFFFFFFF, common_pkg::I_TYPE, common_pkg::ALU_ADD, 6'b100001, 5'd7);
    entry(32'h4030D413, 32'h00000403, common_pkg::I_TYPE, common_pkg::ALU_SHIFT_RIGHT_AR,
          6'b100001, 5'd8);
    entry(32'h07F0F493, 32'h0000007F, common_pkg::I_TYPE, common_pkg::ALU_AND, 6'b100001, 5'd9);
    entry(32'h0080A503, 32'h00000008, common_pkg::I_TYPE, common_pkg::ALU_ADD, 6'b110101, 5'd10);
    entry(32'hFE20AE23, 32'hFFFFFFFC, common_pkg::S_TYPE, common_pkg::ALU_ADD, 6'b101000, 5'd0);
    entry(32'h00208863, 32'h00000010, common_pkg::B_TYPE, common_pkg::ALU_SUB, 6'b000010, 5'd0);
    entry(32'hFE209CE3, 32'hFFFFFFF8, common_pkg::B_TYPE, common_pkg::ALU_SUB, 6'b000010, 5'd0);
    entry(32'h123455B7, 32'h12345000, common_pkg::U_TYPE, common_pkg::ALU_ADD, 6'b100001, 5'd11);
    entry(32'hFFFFF617, 32'hFFFFF000, common_pkg::U_TYPE, common_pkg::ALU_ADD, 6'b100001, 5'd12);
    entry(32'h001000EF, 32'h00000800, common_pkg::J_TYPE, common_pkg::ALU_ADD, 6'b100011, 5'd1);
    entry(32'hFFDFF06F, 32'hFFFFFFFC, common_pkg::J_TYPE, common_pkg::ALU_ADD, 6'b100011, 5'd0);
    entry(32'h000280E7, 32'h0, common_pkg::I_TYPE, common_pkg::ALU_ADD, 6'b100011, 5'd1);
    entry(32'h0020A423, 32'h00000008, common_pkg::S_TYPE, common_pkg::ALU_ADD, 6'b101000, 5'd0);
    entry(32'h00000FFF, 32'h0, common_pkg::R_TYPE, common_pkg::ALU_ADD, 6'b000000, 5'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] value;
    clk         = 1'b0;
    rst         = 1'b1;
    instruction = 32'h0080A503; // a valid load and a write to x1 held through reset.
    pc          = '0;
    in_valid    = 1'b1;
    reg_write   = 1'b1;
    write_id    = 5'd1;
    write_data  = 32'h5A5A5A5A;
    fill_table();
    repeat (5) @(posedge clk);
    rst       <= 1'b0;
    in_valid  <= 1'b0;
    reg_write <= 1'b0;

    @(negedge clk);
    check("reset out_valid", 32'd0, {31'd0, out_valid});
    check("reset control", 32'd0, {14'd0, id_ex.control});
    issue(r_type(5'd1, 5'd0), 32'h0, 1'b0, 5'd0, 32'd0);
    check("reset x1", 32'd0, id_ex.read1_data);

    for (int i = 1; i < 32; i++) begin
      reg_model[i] = next_random();
      write_reg(5'(i), reg_model[i]);
    end
    for (int i = 1; i < 32; i++) begin
      issue(r_type(5'(i), 5'(32 - i)), 32'h100, 1'b0, 5'd0, 32'd0);
      check($sformatf("read x%0d", i), reg_model[i], id_ex.read1_data);
      check($sformatf("read x%0d", 32 - i), reg_model[32 - i], id_ex.read2_data);
    end
    issue(r_type(5'd0, 5'd0), 32'h104, 1'b1, 5'd0, next_random()); // x0 write ignored.
    check("read x0 port 1", 32'd0, id_ex.read1_data);
    check("read x0 port 2", 32'd0, id_ex.read2_data);

    for (int k = 0; k < tab_word.size(); k++) begin
      issue(tab_word[k], 32'h1000 + 32'(4 * k), 1'b0, 5'd0, 32'd0);
      check($sformatf("control %h", tab_word[k]), {14'd0, tab_ctl[k]}, {14'd0, id_ex.control});
      check($sformatf("immediate %h", tab_word[k]), tab_imm[k], id_ex.immediate_data);
      check("table pc", 32'h1000 + 32'(4 * k), id_ex.pc);
    end

    // write and read x5 in one cycle.
    value = next_random();
    issue(r_type(5'd5, 5'd0), 32'h2000, 1'b1, 5'd5, value);
    check("bypass read1", value, id_ex.read1_data);
    check("bypass pc", 32'h2000, id_ex.pc);
    issue(r_type(5'd5, 5'd0), 32'h2004, 1'b0, 5'd0, 32'd0);
    check("stored x5", value, id_ex.read1_data);

    // the instruction stays on the bus while in_valid drops.
    for (int k = 8; k < 14; k += 2) begin
      issue(tab_word[k], 32'h3000, 1'b0, 5'd0, 32'd0);
      @(posedge clk);
      @(negedge clk);
      check("bubble out_valid", 32'd0, {31'd0, out_valid});
      check("bubble control", 32'd0, {14'd0, id_ex.control});
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- decode_asserts.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module decode_asserts (
  input logic                    clk,
  input logic                    rst,
  input logic                    in_valid,
  input logic                    out_valid,
  input common_pkg::id_ex_t      id_ex,
  input logic [`RV_REG_ID_W-1:0] rs1_id,
  input logic [`RV_REG_ID_W-1:0] rs2_id,
  input logic [`RV_XLEN-1:0]     read1_data,
  input logic [`RV_XLEN-1:0]     read2_data
);

  a_reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high after a reset cycle");

  // a bubble must never reach execute as a write.
  a_bubble_no_write: assert property (@(posedge clk) disable iff (rst)
    !in_valid |=> (!id_ex.control.mem_write && !id_ex.control.reg_write))
    else $error("write enable left on after a bubble");

  a_valid_follows: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> (out_valid == $past(in_valid)))
    else $error("out_valid does not follow in_valid");

  a_x0_read1: assert property (@(posedge clk) (rs1_id == '0) |-> (read1_data == '0))
    else $error("x0 read nonzero on port 1");

  a_x0_read2: assert property (@(posedge clk) (rs2_id == '0) |-> (read2_data == '0))
    else $error("x0 read nonzero on port 2");

endmodule

bind decode_top decode_asserts i_decode_asserts (
  .clk        (clk),
  .rst        (rst),
  .in_valid   (in_valid),
  .out_valid  (out_valid),
  .id_ex      (id_ex),
  .rs1_id     (instruction.block3),
  .rs2_id     (instruction.block4),
  .read1_data (stage.read1_data),
  .read2_data (stage.read2_data)
);

//--- decode_top.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module decode_top (
  input  logic                     clk,
  input  logic                     rst,
  input  common_pkg::instruction_t instruction,
  input  logic [`RV_XLEN-1:0]      pc,
  input  logic                     in_valid,
  input  logic                     reg_write,
  input  logic [`RV_REG_ID_W-1:0]  write_id,
  input  logic [`RV_XLEN-1:0]      write_data,
  output logic                     out_valid,
  output common_pkg::id_ex_t       id_ex
);

  common_pkg::id_ex_t stage; // decode outputs packed for execute.

  instruction_decode_stage i_instruction_decode_stage (
    .clk            (clk),
    .rst            (rst),
    .instruction    (instruction),
    .pc             (pc),
    .reg_write      (reg_write),
    .write_id       (write_id),
    .write_data     (write_data),
    .immediate_data (stage.immediate_data),
    .control        (stage.control),
    .read1_data     (stage.read1_data),
    .read2_data     (stage.read2_data),
    .decode_pc      (stage.pc)
  );

  id_ex_reg i_id_ex_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .stage     (stage),
    .out_valid (out_valid),
    .id_ex     (id_ex)
  );

endmodule

//--- id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  common_pkg::id_ex_t stage,
  output logic               out_valid,
  output common_pkg::id_ex_t id_ex
);

  //////////////////////////////////////////////////////////////////////
  // valid and control, cleared on reset and on bubbles
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid     <= 1'b0;
      id_ex.control <= '0;
    end else begin
      out_valid     <= in_valid;
      id_ex.control <= in_valid ? stage.control : '0; // no stray writes.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    id_ex.pc             <= stage.pc;
    id_ex.immediate_data <= stage.immediate_data;
    id_ex.read1_data     <= stage.read1_data;
    id_ex.read2_data     <= stage.read2_data;
  end

endmodule

//--- instruction_decode_stage.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module instruction_decode_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  common_pkg::instruction_t instruction,
  input  logic [`RV_XLEN-1:0]      pc,
  input  logic                     reg_write,
  input  logic [`RV_REG_ID_W-1:0]  write_id,
  input  logic [`RV_XLEN-1:0]      write_data,
  output logic [`RV_XLEN-1:0]      immediate_data,
  output common_pkg::control_t     control,
  output logic [`RV_XLEN-1:0]      read1_data,
  output logic [`RV_XLEN-1:0]      read2_data,
  output logic [`RV_XLEN-1:0]      decode_pc
);

  control i_control (
    .instruction (instruction),
    .control     (control)
  );

  registers i_registers (
    .clk        (clk),
    .rst        (rst),
    .read1_id   (instruction.block3), // rs1.
    .read2_id   (instruction.block4), // rs2.
    .write_id   (write_id),
    .write_en   (reg_write),
    .write_data (write_data),
    .read1_data (read1_data),
    .read2_data (read2_data)
  );

  imm_gen i_imm_gen (
    .instruction      (instruction),
    .control_encoding (control.encoding),
    .immediate_data   (immediate_data)
  );

  // pc of the instruction in decode, for the pipeline register.
  assign decode_pc = pc;

endmodule

//--- imm_gen.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module imm_gen (
  input  common_pkg::instruction_t instruction,
  input  common_pkg::encoding_t    control_encoding,
  output logic [`RV_XLEN-1:0]      immediate_data
);

  logic [`RV_XLEN-1:0] raw;
  logic                sign;

  assign raw  = instruction;
  assign sign = raw[31];

  always_comb begin
    case (control_encoding)
      common_pkg::I_TYPE:
        immediate_data = {{(`RV_XLEN-12){sign}}, raw[31:20]};
      common_pkg::S_TYPE:
        immediate_data = {{(`RV_XLEN-12){sign}}, raw[31:25], raw[11:7]};
      common_pkg::B_TYPE: // lsb always zero.
        immediate_data = {{(`RV_XLEN-13){sign}}, raw[31], raw[7], raw[30:25],
                          raw[11:8], 1'b0};
      common_pkg::U_TYPE:
        immediate_data = {raw[31:12], 12'b0};
      common_pkg::J_TYPE:
        immediate_data = {{(`RV_XLEN-21){sign}}, raw[31], raw[19:12], raw[20],
                          raw[30:21], 1'b0};
      default:
        immediate_data = '0; // r type carries no immediate.
    endcase
  end

endmodule

//--- registers.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module registers (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`RV_REG_ID_W-1:0] read1_id,
  input  logic [`RV_REG_ID_W-1:0] read2_id,
  input  logic [`RV_REG_ID_W-1:0] write_id,
  input  logic                    write_en,
  input  logic [`RV_XLEN-1:0]     write_data,
  output logic [`RV_XLEN-1:0]     read1_data,
  output logic [`RV_XLEN-1:0]     read2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_id != '0) begin
      regs[write_id] <= write_data;
    end
  end

  // x0 reads zero, a same-cycle write is forwarded.
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_ID_W-1:0] id);
    if (id == '0) return '0;
    if (write_en && write_id == id) return write_data;
    return regs[id];
  endfunction

  assign read1_data = read_port(read1_id);
  assign read2_data = read_port(read2_id);

endmodule

//--- control.sv
`timescale 1ns/1ps

module control (
  input  common_pkg::instruction_t instruction,
  output common_pkg::control_t     control
);

  // funct3 to alu op for the register and immediate alu groups.
  // sub only exists in the register form.
  function automatic common_pkg::alu_op_t alu_from_funct3(
    input logic [2:0] funct3,
    input logic       alt,
    input logic       allow_sub
  );
    common_pkg::alu_op_t op;
    case (funct3)
      3'b000: op = (alt && allow_sub) ? common_pkg::ALU_SUB : common_pkg::ALU_ADD;
      3'b001: op = common_pkg::ALU_SHIFT_LEFT;
      3'b010: op = common_pkg::ALU_LESS_THAN_SIGNED;
      3'b011: op = common_pkg::ALU_LESS_THAN_UNSIGNED;
      3'b100: op = common_pkg::ALU_XOR;
      3'b101: op = alt ? common_pkg::ALU_SHIFT_RIGHT_AR : common_pkg::ALU_SHIFT_RIGHT;
      3'b110: op = common_pkg::ALU_OR;
      default: op = common_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  common_pkg::opcode_t opcode;
  logic                alt;

  assign opcode = common_pkg::opcode_t'(instruction.block1);
  assign alt    = instruction.block6[5]; // funct7 bit 5.

  always_comb begin
    // safe default, also what an unknown opcode ends up with.
    control          = '0;
    control.encoding = common_pkg::R_TYPE;
    control.alu_op   = common_pkg::ALU_ADD;

    case (opcode)
      common_pkg::OP: begin
        control.alu_op    = alu_from_funct3(instruction.block5, alt, 1'b1);
        control.reg_write = 1'b1;
      end
      common_pkg::OP_IMM: begin
        control.encoding  = common_pkg::I_TYPE;
        control.alu_op    = alu_from_funct3(instruction.block5, alt, 1'b0);
        control.alu_src   = 1'b1;
        control.reg_write = 1'b1;
      end
      common_pkg::LOAD: begin
        control.encoding   = common_pkg::I_TYPE;
        control.alu_src    = 1'b1;
        control.mem_read   = 1'b1;
        control.mem_to_reg = 1'b1;
        control.reg_write  = 1'b1;
      end
      common_pkg::STORE: begin
        control.encoding  = common_pkg::S_TYPE;
        control.alu_src   = 1'b1;
        control.mem_write = 1'b1;
      end
      common_pkg::BRANCH: begin
        control.encoding  = common_pkg::B_TYPE;
        control.alu_op    = common_pkg::ALU_SUB; // compare by subtraction.
        control.is_branch = 1'b1;
      end
      common_pkg::LUI, common_pkg::AUIPC: begin
        control.encoding  = common_pkg::U_TYPE;
        control.alu_src   = 1'b1;
        control.reg_write = 1'b1;
      end
      common_pkg::JAL: begin
        control.encoding  = common_pkg::J_TYPE;
        control.alu_src   = 1'b1;
        control.is_branch = 1'b1;
        control.reg_write = 1'b1;
      end
      common_pkg::JALR: begin
        control.encoding  = common_pkg::I_TYPE;
        control.alu_src   = 1'b1;
        control.is_branch = 1'b1;
        control.reg_write = 1'b1;
      end
      default: begin
      end
    endcase

    // destination only named when something is written back.
    if (control.reg_write) begin
      control.write_back_id = instruction.block2;
    end
  end

endmodule

//--- common_pkg.sv
`include "rv_cfg.svh"

package common_pkg;

  //////////////////////////////////////////////////////////////////////
  // instruction word and opcodes
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]              block6; // funct7.
    logic [`RV_REG_ID_W-1:0] block4; // rs2.
    logic [`RV_REG_ID_W-1:0] block3; // rs1.
    logic [2:0]              block5; // funct3.
    logic [`RV_REG_ID_W-1:0] block2; // rd.
    logic [6:0]              block1; // opcode.
  } instruction_t;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111
  } opcode_t;

  //////////////////////////////////////////////////////////////////////
  // control bundle
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
  } encoding_t;

  typedef enum logic [3:0] {
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_ADD,
    ALU_SUB,
    ALU_SHIFT_LEFT,
    ALU_SHIFT_RIGHT,
    ALU_SHIFT_RIGHT_AR,
    ALU_LESS_THAN_UNSIGNED,
    ALU_LESS_THAN_SIGNED
  } alu_op_t;

  typedef struct packed {
    encoding_t               encoding;
    alu_op_t                 alu_op;
    logic                    alu_src;    // operand b from the immediate.
    logic                    mem_read;
    logic                    mem_write;
    logic                    mem_to_reg;
    logic                    is_branch;
    logic                    reg_write;
    logic [`RV_REG_ID_W-1:0] write_back_id;
  } control_t;

  // what decode hands to execute.
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    control_t            control;
    logic [`RV_XLEN-1:0] immediate_data;
    logic [`RV_XLEN-1:0] read1_data;
    logic [`RV_XLEN-1:0] read2_data;
  } id_ex_t;

endpackage

//--- rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// rv32i widths, fixed by the isa.
`define RV_XLEN     32
`define RV_NUM_REGS 32
`define RV_REG_ID_W 5

`endif
